//--- hci_ecc_pkg.sv
// shared widths for the 39/32 SECDED link; only DW=32 is supported and UW=0 is widened to 1 bit
package hci_ecc_pkg;

  // data and byte address widths of the core interface
  localparam int unsigned DW = 32;
  localparam int unsigned AW = 32;

  // user sideband without ECC, none in this build
  localparam int unsigned UW = 0;
  // width actually carried on the bank-side bus, never zero
  localparam int unsigned UW_W = (UW > 0) ? UW : 1;

  // SECDED check bits for 32 data bits
  localparam int unsigned NB_ECC_BITS = 7;
  // check bits ride in the upper user bits of the link
  localparam int unsigned ECC_UW = UW + NB_ECC_BITS;
  // full codeword, check bits above data
  localparam int unsigned CW = DW + NB_ECC_BITS;

  localparam int unsigned BE_W = DW / 8;

  // bank geometry, word index taken from add[9:2]
  localparam int unsigned BANK_WORDS = 256;
  localparam int unsigned BANK_AW = $clog2(BANK_WORDS);

  // Hsiao columns for data bits 0..31, all weight 3 and distinct
  // check bit j has the unit column (1 << j)
  localparam logic [NB_ECC_BITS-1:0] HSIAO_COLS [DW] = '{
    7'h0B, 7'h13, 7'h23, 7'h43, 7'h0D, 7'h15, 7'h25, 7'h45,
    7'h19, 7'h29, 7'h49, 7'h31, 7'h51, 7'h61, 7'h0E, 7'h16,
    7'h26, 7'h46, 7'h1A, 7'h2A, 7'h4A, 7'h32, 7'h52, 7'h62,
    7'h1C, 7'h2C, 7'h4C, 7'h34, 7'h54, 7'h64, 7'h58, 7'h68
  };

  // error class reported by every decoder
  typedef enum logic [1:0] {
    ERR_NONE   = 2'b00,
    ERR_SINGLE = 2'b01,
    ERR_DOUBLE = 2'b10
  } ecc_err_e;

endpackage

//--- hci_core_intf.sv
// HCI-style core bus without lrdy/boffs/opc sideband; USER_W must be at least 1
`timescale 1ns/1ps

interface hci_core_intf import hci_ecc_pkg::*; #(
  parameter int unsigned USER_W = ECC_UW
) ();

  // request side, transfers when req and gnt are both high
  logic              req;
  logic              gnt;
  logic [AW-1:0]     add;
  // high for read, low for write
  logic              wen;
  logic [DW-1:0]     data;
  logic [BE_W-1:0]   be;
  logic [USER_W-1:0] user;

  // response side, r_valid one cycle after each transfer
  logic [DW-1:0]     r_data;
  logic              r_valid;
  logic [USER_W-1:0] r_user;

  modport initiator (
    output req, add, wen, data, be, user,
    input  gnt, r_data, r_valid, r_user
  );

  modport target (
    input  req, add, wen, data, be, user,
    output gnt, r_data, r_valid, r_user
  );

endinterface

//--- secded_39_32_enc.sv
// combinational Hsiao SECDED encoder, 32 data bits in, codeword {check[6:0], data[31:0]} out
`timescale 1ns/1ps

module secded_39_32_enc import hci_ecc_pkg::*; (
  input  logic [DW-1:0] data_i,
  output logic [CW-1:0] code_o
);

  logic [NB_ECC_BITS-1:0] chk;

  // each check bit is the XOR of the data bits whose column has that row set
  always_comb begin
    chk = '0;
    for (int i = 0; i < DW; i++) begin
      if (data_i[i]) begin
        chk = chk ^ HSIAO_COLS[i];
      end
    end
  end

  // systematic code, data passes through unchanged
  assign code_o = {chk, data_i};

endmodule

//--- secded_39_32_dec.sv
// combinational SECDED decoder; corrects one flipped bit, flags two, three or more may miscorrect
`timescale 1ns/1ps

module secded_39_32_dec import hci_ecc_pkg::*; (
  input  logic [CW-1:0]          code_i,
  output logic [DW-1:0]          data_o,
  output logic [NB_ECC_BITS-1:0] syndrome_o,
  output ecc_err_e               err_o
);

  logic [DW-1:0]          data_rx;
  logic [NB_ECC_BITS-1:0] chk_rx;
  logic [NB_ECC_BITS-1:0] chk_calc;
  logic [NB_ECC_BITS-1:0] syndrome;
  logic [DW-1:0]          flip;

  assign data_rx = code_i[DW-1:0];
  assign chk_rx  = code_i[CW-1:DW];

  // check bits recomputed from the received data
  always_comb begin
    chk_calc = '0;
    for (int i = 0; i < DW; i++) begin
      if (data_rx[i]) begin
        chk_calc = chk_calc ^ HSIAO_COLS[i];
      end
    end
  end

  assign syndrome = chk_calc ^ chk_rx;

  // a data bit is flipped only when the syndrome equals its column
  // even-weight syndromes never match a weight-3 column, so doubles pass as received
  always_comb begin
    for (int i = 0; i < DW; i++) begin
      flip[i] = (syndrome == HSIAO_COLS[i]);
    end
  end

  assign data_o     = data_rx ^ flip;
  assign syndrome_o = syndrome;

  // odd weight means one bit, also when it hit a check bit
  always_comb begin
    if (syndrome == '0) begin
      err_o = ERR_NONE;
    end else if (^syndrome) begin
      err_o = ERR_SINGLE;
    end else begin
      err_o = ERR_DOUBLE;
    end
  end

endmodule

//--- hci_core_intf_ecc_enc.sv
// initiator-side ECC adapter, zero latency; inj_mask_i corrupts every request while it is nonzero
`timescale 1ns/1ps

module hci_core_intf_ecc_enc import hci_ecc_pkg::*; (
  input  logic                   req_i,
  output logic                   gnt_o,
  input  logic [AW-1:0]          add_i,
  input  logic                   wen_i,
  input  logic [DW-1:0]          data_i,
  input  logic [BE_W-1:0]        be_i,
  input  logic [CW-1:0]          inj_mask_i,
  output logic [DW-1:0]          r_data_o,
  output logic                   r_valid_o,
  hci_core_intf.initiator        bus_o,
  output logic [NB_ECC_BITS-1:0] syndrome_o,
  output ecc_err_e               err_o
);

  logic [CW-1:0] wr_code;
  logic [CW-1:0] wr_code_inj;

  // handshake and address fields cross unchanged
  assign bus_o.req = req_i;
  assign gnt_o     = bus_o.gnt;
  assign bus_o.add = add_i;
  assign bus_o.wen = wen_i;
  assign bus_o.be  = be_i;

  // protect write data, codeword is {check, data}
  secded_39_32_enc u_wr_enc (
    .data_i ( data_i  ),
    .code_o ( wr_code )
  );

  // fault injection may hit data and check bits alike
  assign wr_code_inj = wr_code ^ inj_mask_i;

  assign bus_o.data                = wr_code_inj[DW-1:0];
  assign bus_o.user[ECC_UW-1:UW]   = wr_code_inj[CW-1:DW];

  // plain user bits below the check bits, none are sourced here
  if (UW > 0) begin : g_user
    assign bus_o.user[UW-1:0] = '0;
  end

  // check and correct what comes back over the link
  secded_39_32_dec u_rd_dec (
    .code_i     ( {bus_o.r_user[ECC_UW-1:UW], bus_o.r_data} ),
    .data_o     ( r_data_o                                  ),
    .syndrome_o ( syndrome_o                                ),
    .err_o      ( err_o                                     )
  );

  assign r_valid_o = bus_o.r_valid;

endmodule

//--- hci_core_intf_ecc_dec.sv
// target-side ECC adapter, zero latency; double errors are flagged only, never handled
`timescale 1ns/1ps

module hci_core_intf_ecc_dec import hci_ecc_pkg::*; (
  hci_core_intf.target           bus_in,
  hci_core_intf.initiator        bus_out,
  output logic [NB_ECC_BITS-1:0] syndrome_o,
  output ecc_err_e               err_o
);

  logic [CW-1:0] rd_code;

  // handshake and address path straight through
  assign bus_out.req    = bus_in.req;
  assign bus_in.gnt     = bus_out.gnt;
  assign bus_out.add    = bus_in.add;
  assign bus_out.wen    = bus_in.wen;
  assign bus_out.be     = bus_in.be;
  assign bus_in.r_valid = bus_out.r_valid;

  // plain user bits sit below the check bits on the link
  if (UW > 0) begin : g_user
    assign bus_out.user              = bus_in.user[UW-1:0];
    assign bus_in.r_user[UW-1:0]     = bus_out.r_user[UW-1:0];
  end else begin : g_no_user
    // spare bit of the bank-side bus
    assign bus_out.user = '0;
  end

  // write data checked and stripped before the bank
  secded_39_32_dec u_wr_dec (
    .code_i     ( {bus_in.user[ECC_UW-1:UW], bus_in.data} ),
    .data_o     ( bus_out.data                            ),
    .syndrome_o ( syndrome_o                              ),
    .err_o      ( err_o                                   )
  );

  // read data protected again before it crosses the link
  secded_39_32_enc u_rd_enc (
    .data_i ( bus_out.r_data ),
    .code_o ( rd_code        )
  );

  assign bus_in.r_data                = rd_code[DW-1:0];
  assign bus_in.r_user[ECC_UW-1:UW]   = rd_code[CW-1:DW];

endmodule

//--- tcdm_bank.sv
// single-port 256x32 bank, always grants, contents undefined after reset, add bits above 9 ignored
`timescale 1ns/1ps

module tcdm_bank import hci_ecc_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_n_i,
  hci_core_intf.target bus
);

  logic [DW-1:0]      mem_q [BANK_WORDS];
  logic [BANK_AW-1:0] idx;
  logic               xfer;
  logic [DW-1:0]      r_data_q;
  logic [UW_W-1:0]    r_user_q;
  logic               r_valid_q;

  // no back-pressure
  assign bus.gnt = bus.req;
  assign xfer    = bus.req & bus.gnt;

  // word index from the byte address
  assign idx = bus.add[BANK_AW+1:2];

  // byte-masked write, wen low means write
  always_ff @(posedge clk_i) begin
    if (xfer && !bus.wen) begin
      for (int b = 0; b < BE_W; b++) begin
        if (bus.be[b]) begin
          mem_q[idx][8*b +: 8] <= bus.data[8*b +: 8];
        end
      end
    end
  end

  // response payload captured on every transfer
  // read returns contents from before a same-cycle write
  always_ff @(posedge clk_i) begin
    if (xfer) begin
      r_data_q <= mem_q[idx];
      r_user_q <= bus.user;
    end
  end

  // one valid pulse per transfer, reads and writes alike
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      r_valid_q <= 1'b0;
    end else begin
      r_valid_q <= xfer;
    end
  end

  assign bus.r_data  = r_data_q;
  assign bus.r_user  = r_user_q;
  assign bus.r_valid = r_valid_q;

endmodule

//--- hci_ecc_top.sv
// ECC-protected bank path, one request in flight; keep req_i and fields stable until gnt_o
`timescale 1ns/1ps

module hci_ecc_top import hci_ecc_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   req_i,
  output logic                   gnt_o,
  input  logic [AW-1:0]          add_i,
  input  logic                   wen_i,
  input  logic [DW-1:0]          data_i,
  input  logic [BE_W-1:0]        be_i,
  input  logic [CW-1:0]          inj_mask_i,
  output logic [DW-1:0]          r_data_o,
  output logic                   r_valid_o,
  output logic [NB_ECC_BITS-1:0] wr_syndrome_o,
  output ecc_err_e               wr_err_o,
  output logic [NB_ECC_BITS-1:0] rd_syndrome_o,
  output ecc_err_e               rd_err_o
);

  // protected link carries the check bits in user
  hci_core_intf #(.USER_W(ECC_UW)) link ();
  // bank side, plain data
  hci_core_intf #(.USER_W(UW_W)) mem ();

  // initiator side, read-error report comes from here
  hci_core_intf_ecc_enc u_ecc_enc (
    .req_i      ( req_i         ),
    .gnt_o      ( gnt_o         ),
    .add_i      ( add_i         ),
    .wen_i      ( wen_i         ),
    .data_i     ( data_i        ),
    .be_i       ( be_i          ),
    .inj_mask_i ( inj_mask_i    ),
    .r_data_o   ( r_data_o      ),
    .r_valid_o  ( r_valid_o     ),
    .bus_o      ( link          ),
    .syndrome_o ( rd_syndrome_o ),
    .err_o      ( rd_err_o      )
  );

  // target side, write-error report comes from here
  hci_core_intf_ecc_dec u_ecc_dec (
    .bus_in     ( link          ),
    .bus_out    ( mem           ),
    .syndrome_o ( wr_syndrome_o ),
    .err_o      ( wr_err_o      )
  );

  tcdm_bank u_bank (
    .clk_i   ( clk_i   ),
    .rst_n_i ( rst_n_i ),
    .bus     ( mem     )
  );

endmodule

//--- tb_hci_ecc.sv
// self-checking testbench, one request at a time; expects hci_ecc_patterns.txt in the run folder
`timescale 1ns/1ps

module tb_hci_ecc import hci_ecc_pkg::*; ();

  logic                   clk_i;
  logic                   rst_n_i;
  logic                   req_i;
  logic                   gnt_o;
  logic [AW-1:0]          add_i;
  logic                   wen_i;
  logic [DW-1:0]          data_i;
  logic [BE_W-1:0]        be_i;
  logic [CW-1:0]          inj_mask_i;
  logic [DW-1:0]          r_data_o;
  logic                   r_valid_o;
  logic [NB_ECC_BITS-1:0] wr_syndrome_o;
  ecc_err_e               wr_err_o;
  logic [NB_ECC_BITS-1:0] rd_syndrome_o;
  ecc_err_e               rd_err_o;

  // expected bank contents, built from the write rules
  logic [DW-1:0] model_mem [BANK_WORDS];
  int            pass_cnt;
  int            fail_cnt;
  int            test_num;
  int            test_errs;
  integer        seed;

  hci_ecc_top dut_i (
    .clk_i(clk_i), .rst_n_i(rst_n_i), .req_i(req_i), .gnt_o(gnt_o), .add_i(add_i),
    .wen_i(wen_i), .data_i(data_i), .be_i(be_i), .inj_mask_i(inj_mask_i),
    .r_data_o(r_data_o), .r_valid_o(r_valid_o), .wr_syndrome_o(wr_syndrome_o),
    .wr_err_o(wr_err_o), .rd_syndrome_o(rd_syndrome_o), .rd_err_o(rd_err_o)
  );

  // 40 ns period
  always #20 clk_i = ~clk_i;

  // one request through the path, write class checked while it is on the bus
  task automatic run_request(input logic rd, input logic [AW-1:0] addr,
                             input logic [DW-1:0] wdata, input logic [BE_W-1:0] be,
                             input logic [CW-1:0] mask, input logic [1:0] exp_wr_err,
                             input logic [DW-1:0] exp_rdata, input logic [1:0] exp_rd_err);
    int                 cycles;
    logic               got;
    logic [DW-1:0]      stored;
    logic [BANK_AW-1:0] idx;
    idx       = addr[BANK_AW+1:2];
    test_errs = 0;
    @(posedge clk_i);
    #2;
    req_i      = 1'b1;
    add_i      = addr;
    wen_i      = rd;
    data_i     = wdata;
    be_i       = be;
    inj_mask_i = mask;
    // hold the request until granted
    cycles = 0;
    @(negedge clk_i);
    while (!gnt_o && cycles < 20) begin
      @(negedge clk_i);
      cycles++;
    end
    if (!gnt_o) begin
      $display("no grant within 20 cycles for address %h", addr);
      test_errs++;
    end
    assert (wr_err_o == exp_wr_err) else begin
      $display("MISMATCH t=%0t wr_err_o %b expected %b", $time, wr_err_o, exp_wr_err);
      test_errs++;
    end
    // zero syndrome exactly when the write crossed clean
    if (exp_wr_err == ERR_NONE) begin
      assert (wr_syndrome_o == '0) else begin
        $display("MISMATCH t=%0t wr_syndrome_o %h on a clean write", $time, wr_syndrome_o);
        test_errs++;
      end
    end else begin
      assert (wr_syndrome_o != '0) else begin
        $display("MISMATCH t=%0t wr_syndrome_o zero on a detected error", $time);
        test_errs++;
      end
    end
    // accepting edge
    @(posedge clk_i);
    #2;
    req_i      = 1'b0;
    inj_mask_i = '0;
    // one flipped bit is corrected, two flipped data bits reach the bank
    if (!rd) begin
      stored = ($countones(mask) == 2) ? (wdata ^ mask[DW-1:0]) : wdata;
      for (int b = 0; b < BE_W; b++) begin
        if (be[b]) begin
          model_mem[idx][8*b +: 8] = stored[8*b +: 8];
        end
      end
    end
    cycles = 0;
    got    = 1'b0;
    while (!got && cycles < 20) begin
      @(negedge clk_i);
      cycles++;
      got = r_valid_o;
    end
    if (!got) begin
      $display("no response within 20 cycles");
      test_errs++;
    end else begin
      assert (cycles == 1) else begin
        $display("MISMATCH t=%0t r_valid_o after %0d cycles, expected 1", $time, cycles);
        test_errs++;
      end
      // read data and its code are meaningful only for reads
      if (rd) begin
        assert (rd_err_o == exp_rd_err) else begin
          $display("MISMATCH t=%0t rd_err_o %b expected %b", $time, rd_err_o, exp_rd_err);
          test_errs++;
        end
        assert ((rd_syndrome_o == '0) == (exp_rd_err == ERR_NONE)) else begin
          $display("MISMATCH t=%0t rd_syndrome_o %h with rd_err_o expected %b", $time,
                   rd_syndrome_o, exp_rd_err);
          test_errs++;
        end
        assert (r_data_o == exp_rdata && r_data_o == model_mem[idx]) else begin
          $display("MISMATCH t=%0t r_data_o %h expected %h, model %h", $time, r_data_o,
                   exp_rdata, model_mem[idx]);
          test_errs++;
        end
      end
      // valid lasts exactly one cycle
      @(negedge clk_i);
      assert (!r_valid_o) else begin
        $display("MISMATCH t=%0t r_valid_o longer than one cycle", $time);
        test_errs++;
      end
    end
  endtask

  task automatic finish_test(input string what);
    test_num++;
    if (test_errs == 0) begin
      pass_cnt++;
      $display("test %0d %s ok", test_num, what);
    end else begin
      fail_cnt++;
      $display("test %0d %s failed, %0d errors", test_num, what, test_errs);
    end
  endtask

  initial begin
    int            fd;
    int            n;
    string         line;
    string         op_name;
    logic          f_rd;
    logic [AW-1:0] f_addr;
    logic [DW-1:0] f_data;
    logic [DW-1:0] f_rdata;
    logic [BE_W-1:0] f_be;
    logic [CW-1:0] f_mask;
    logic [1:0]    f_wr_err;
    logic [1:0]    f_rd_err;
    logic [DW-1:0] rnd;
    clk_i = 1'b0;
    rst_n_i = 1'b0;
    req_i = 1'b0;
    add_i = '0;
    wen_i = 1'b1;
    data_i = '0;
    be_i = '0;
    inj_mask_i = '0;
    pass_cnt = 0;
    fail_cnt = 0;
    test_num = 0;
    seed = 32'ha97c06c1;
    repeat (4) @(posedge clk_i);
    #2;
    rst_n_i = 1'b1;
    // idle bus, no response may appear
    test_errs = 0;
    repeat (4) begin
      @(negedge clk_i);
      assert (!r_valid_o) else begin
        $display("MISMATCH t=%0t r_valid_o high without a request", $time);
        test_errs++;
      end
    end
    finish_test("idle after reset");
    fd = $fopen("hci_ecc_patterns.txt", "r");
    if (fd == 0) begin
      $display("could not open hci_ecc_patterns.txt");
      fail_cnt++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        // comment and blank lines give fewer than 8 fields
        n = $sscanf(line, "%h %h %h %h %h %h %h %h", f_rd, f_addr, f_data, f_be, f_mask,
                    f_rdata, f_wr_err, f_rd_err);
        if (n == 8) begin
          run_request(f_rd, f_addr, f_data, f_be, f_mask, f_wr_err, f_rdata, f_rd_err);
          if (f_rd) begin
            op_name = "read";
          end else begin
            op_name = "write";
          end
          finish_test($sformatf("pattern %s %h", op_name, f_addr));
        end
      end
      $fclose(fd);
    end
    // single flip in each of the 39 codeword positions
    for (int k = 0; k < CW; k++) begin
      rnd = $random(seed);
      f_addr = 32'h200 + 4 * k;
      f_mask = '0;
      f_mask[k] = 1'b1;
      run_request(1'b0, f_addr, rnd, 4'hf, f_mask, ERR_SINGLE, '0, ERR_NONE);
      finish_test($sformatf("single flip bit %0d write", k));
      run_request(1'b1, f_addr, '0, 4'hf, '0, ERR_NONE, rnd, ERR_NONE);
      finish_test($sformatf("single flip bit %0d read", k));
    end
    // clean random words at random bank rows
    repeat (8) begin
      rnd = $random(seed);
      f_addr = {22'h0, rnd[7:0], 2'b00};
      rnd = $random(seed);
      run_request(1'b0, f_addr, rnd, 4'hf, '0, ERR_NONE, '0, ERR_NONE);
      run_request(1'b1, f_addr, '0, 4'hf, '0, ERR_NONE, rnd, ERR_NONE);
      finish_test($sformatf("random pair %h", f_addr));
    end
    $display("tests passed %0d failed %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- hci_ecc_patterns.txt
# op(0 write, 1 read) addr data be inj_mask(39 bit) exp_rdata exp_wr_err exp_rd_err, all hex
# exp_rdata is ignored on writes; error classes 0 none, 1 single, 2 double
0 00000000 deadbeef f 0000000000 00000000 0 0
0 00000004 12345678 f 0000000000 00000000 0 0
1 00000000 00000000 f 0000000000 deadbeef 0 0
1 00000004 00000000 f 0000000000 12345678 0 0
0 00000004 aabbccdd 5 0000000000 00000000 0 0
1 00000004 00000000 f 0000000000 12bb56dd 0 0
0 00000010 cafef00d f 0080000000 00000000 1 0
0 00000014 0badc0de f 4000000000 00000000 1 0
1 00000010 00000000 f 0000000000 cafef00d 0 0
1 00000014 00000000 f 0000000000 0badc0de 0 0
0 00000020 ffffffff f 0800000010 00000000 2 0
0 00000024 13579bdf f 0300000000 00000000 2 0
1 00000020 00000000 f 0000000000 ffffffef 0 0
1 00000024 00000000 f 0000000000 13579bdf 0 0

//--- flist.f
hci_ecc_pkg.sv
hci_core_intf.sv
secded_39_32_enc.sv
secded_39_32_dec.sv
hci_core_intf_ecc_enc.sv
hci_core_intf_ecc_dec.sv
tcdm_bank.sv
hci_ecc_top.sv
tb_hci_ecc.sv

//--- run_sim.sh
#!/bin/sh
# builds and runs tb_hci_ecc with Verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_hci_ecc -f flist.f > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "verilator build failed"
  exit 1
fi

./obj_dir/Vtb_hci_ecc > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

# verdict comes from the log
if grep -q "TEST RESULT: FAIL" sim.log; then
  exit 1
fi
if ! grep -q "TEST RESULT: PASS" sim.log; then
  echo "no verdict found in sim.log"
  exit 1
fi
exit 0
